/* if_stage.f */
common/if_pkg.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_buffer.sv
verilog/pc_select.sv
verilog/if_id_reg.sv
verilog/if_stage.sv
tb/instr_mem_model.sv
tb/tb_if_stage.sv

/* tb/if_stage_tests.txt */
# name sel(0 boot 1 jump 2 exc 3 eret 4 dret) exc irq addr mtvec err_lo err_hi count stall%
# addr is boot address, jump target, mepc or depc; err_lo > err_hi means no error range
boot       0 0 0  00001000 00002000 ffffffff 00000000  8  0
jump       1 0 0  00001400 00002000 ffffffff 00000000 10  0
exc        2 0 0  00000000 00002040 ffffffff 00000000  6  0
irq_5      2 1 5  00000000 00002040 ffffffff 00000000  6 10
irq_31     2 1 31 00000000 00003000 ffffffff 00000000  4  0
dbg_halt   2 2 0  00000000 00002040 ffffffff 00000000  5  0
dbg_exc    2 3 0  00000000 00002040 ffffffff 00000000  5 20
eret       3 0 0  00003104 00002040 ffffffff 00000000  7  0
dret       4 0 0  00004208 00002040 ffffffff 00000000  7  0
stall      1 0 0  00005000 00002040 ffffffff 00000000 16 60
bus_err    1 0 0  00006000 00002040 00006008 0000600c 10 20
boot_again 0 0 0  00007000 00002040 00007010 00007010  8 40

/* tb/tb_if_stage.sv */
// testbench for the instruction fetch stage
// replays the test table against the bus memory model and checks
// every word that reaches decode

`timescale 1ns/1ns

module tb_if_stage;
  import if_pkg::*;

  localparam int unsigned MAX_TESTS = 32;
  localparam int unsigned SEED      = 32'hfb16_8897;
  localparam pc_t         DATA_KEY  = 32'hA5A5_0000;

  logic           clk;
  logic           rst_n;
  pc_t            boot_addr;
  logic           fetch_req;
  pc_ctrl_t       pc_ctrl;
  csr_pc_t        csr;
  pc_t            jump_target;
  instr_bus_req_t bus_req;
  instr_bus_rsp_t bus_rsp;
  logic           id_ready;
  logic           valid_clear;
  id_instr_t      instr_id;
  logic           instr_valid;
  logic           instr_new;
  pc_t            pc_if;
  logic           mtvec_init;
  logic           if_busy;
  pc_t            err_lo;
  pc_t            err_hi;

  // test table
  string       t_name  [MAX_TESTS];
  pc_sel_e     t_sel   [MAX_TESTS];
  exc_pc_sel_e t_exc   [MAX_TESTS];
  logic [4:0]  t_irq   [MAX_TESTS];
  pc_t         t_addr  [MAX_TESTS];
  pc_t         t_mtvec [MAX_TESTS];
  pc_t         t_lo    [MAX_TESTS];
  pc_t         t_hi    [MAX_TESTS];
  int unsigned t_count [MAX_TESTS];
  int unsigned t_stall [MAX_TESTS];
  int unsigned n_tests;
  int unsigned total_words;

  int unsigned cycle_limit = 32'hffff_ffff;
  int unsigned cycle_cnt   = 0;
  int unsigned rnd;
  int unsigned errors      = 0;
  int unsigned checks      = 0;
  int unsigned test_errors;

  // decode model state
  string       cur_name;
  pc_t         start_pc;
  int unsigned want;
  int unsigned got;
  int unsigned skip;
  int unsigned stall_pct   = 0;
  // granted but unanswered fetches seen on the bus
  int unsigned outst       = 0;
  int unsigned max_outst   = 0;
  // buffer head address seen in the previous cycle
  pc_t         head_pc;

  if_stage i_if_stage (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .boot_addr_i         (boot_addr),
    .req_i               (fetch_req),
    .pc_ctrl_i           (pc_ctrl),
    .csr_i               (csr),
    .jump_target_i       (jump_target),
    .bus_req_o           (bus_req),
    .bus_rsp_i           (bus_rsp),
    .id_in_ready_i       (id_ready),
    .instr_valid_clear_i (valid_clear),
    .instr_id_o          (instr_id),
    .instr_valid_id_o    (instr_valid),
    .instr_new_id_o      (instr_new),
    .pc_if_o             (pc_if),
    .csr_mtvec_init_o    (mtvec_init),
    .if_busy_o           (if_busy)
  );

  instr_mem_model i_instr_mem_model (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .bus_req_i (bus_req),
    .err_lo_i  (err_lo),
    .err_hi_i  (err_hi),
    .bus_rsp_o (bus_rsp)
  );

  always #10 clk = ~clk;

  // watchdog with its limit taken from the total word count of the table
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, test %s stuck at %0d of %0d words",
               cycle_cnt, cur_name, got, want);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_instr(input string name, input id_instr_t exp, input id_instr_t act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_pc(input string name, input pc_t exp, input pc_t act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus and decode model
  //////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    string name;
    int    sel;
    int    exc;
    int    irq;
    int    cnt;
    int    stall;
    pc_t   addr;
    pc_t   mtvec;
    pc_t   lo;
    pc_t   hi;
    n_tests     = 0;
    total_words = 0;
    fd = $fopen("tb/if_stage_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test table tb/if_stage_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = "";
        n    = $fgets(line, fd);
        // comment lines start with a hash
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %d %d %d %h %h %h %h %d %d",
                      name, sel, exc, irq, addr, mtvec, lo, hi, cnt, stall);
          if (n == 10) begin
            t_name[n_tests]  = name;
            t_sel[n_tests]   = pc_sel_e'(sel[2:0]);
            t_exc[n_tests]   = exc_pc_sel_e'(exc[1:0]);
            t_irq[n_tests]   = irq[4:0];
            t_addr[n_tests]  = addr;
            t_mtvec[n_tests] = mtvec;
            t_lo[n_tests]    = lo;
            t_hi[n_tests]    = hi;
            t_count[n_tests] = cnt;
            t_stall[n_tests] = stall;
            total_words      = total_words + cnt;
            n_tests++;
          end else begin
            $display("malformed line in the test table: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // first fetch address of a redirect by the vector rules
  function automatic pc_t expected_start(input pc_sel_e sel, input exc_pc_sel_e exc,
                                         input logic [4:0] irq, input pc_t addr,
                                         input pc_t mtvec);
    pc_t base;
    pc_t res;
    base = mtvec & 32'hFFFF_FF00;
    case (sel)
      PC_BOOT: res = addr & 32'hFFFF_FF00;
      PC_EXC: begin
        case (exc)
          EXC_PC_EXC: res = base;
          EXC_PC_IRQ: res = base + pc_t'({irq, 2'b00});
          EXC_PC_DBD: res = DM_HALT_ADDR;
          default:    res = DM_EXC_ADDR;
        endcase
      end
      // jump target, mepc and depc all arrive as the operand
      default: res = addr;
    endcase
    return res;
  endfunction

  // one clock sampled at the edge before any register update
  task automatic step_cycle();
    id_instr_t exp;
    pc_t       pc;
    @(posedge clk);
    // a request on the bus or a fetch still in flight keeps the stage busy
    if (bus_req.req || outst != 0) begin
      check_flag({cur_name, " busy"}, 1'b1, if_busy);
    end
    if (bus_req.req && bus_rsp.gnt) begin
      outst++;
    end
    if (bus_rsp.rvalid && outst != 0) begin
      outst--;
    end
    if (outst > max_outst) begin
      max_outst = outst;
    end
    // words popped up to the pc_set cycle are from the old stream
    if (skip != 0) begin
      skip--;
    end else if (instr_new && got < want) begin
      pc            = start_pc + pc_t'(4 * got);
      exp.instr     = pc ^ DATA_KEY;
      exp.pc        = pc;
      exp.fetch_err = (pc >= err_lo) && (pc <= err_hi);
      check_instr(cur_name, exp, instr_id);
      // the popped word sat at the buffer head one cycle earlier
      check_pc({cur_name, " head pc"}, pc, head_pc);
      check_flag({cur_name, " valid"}, 1'b1, instr_valid);
      got++;
    end
    head_pc     = pc_if;
    valid_clear <= instr_new;
    id_ready    <= ($urandom % 100) >= stall_pct;
  endtask

  task automatic check_reset();
    cur_name    = "reset";
    test_errors = 0;
    repeat (4) begin
      step_cycle();
      check_flag("reset instr_req", 1'b0, bus_req.req);
      check_flag("reset instr_valid", 1'b0, instr_valid);
      check_flag("reset instr_new", 1'b0, instr_new);
      check_flag("reset mtvec_init", 1'b0, mtvec_init);
      check_flag("reset if_busy", 1'b0, if_busy);
    end
    $display("test %s: no fetch before the first pc_set, %0d errors", cur_name, test_errors);
  endtask

  task automatic run_test(input int unsigned idx);
    cur_name    = t_name[idx];
    test_errors = 0;
    start_pc    = expected_start(t_sel[idx], t_exc[idx], t_irq[idx], t_addr[idx],
                                 t_mtvec[idx]);
    want        = t_count[idx];
    got         = 0;
    skip        = 2;
    max_outst   = outst;
    stall_pct   = t_stall[idx];
    if (t_sel[idx] == PC_BOOT) begin
      boot_addr <= t_addr[idx];
    end
    jump_target <= t_addr[idx];
    csr.mepc    <= t_addr[idx];
    csr.depc    <= t_addr[idx];
    csr.mtvec   <= t_mtvec[idx];
    err_lo      <= t_lo[idx];
    err_hi      <= t_hi[idx];
    pc_ctrl     <= '{pc_set: 1'b1, pc_mux: t_sel[idx], exc_pc_mux: t_exc[idx],
                     irq_id: t_irq[idx]};
    step_cycle();
    // mtvec init is seen only in the pc_set cycle of a boot
    check_flag({cur_name, " mtvec init"}, t_sel[idx] == PC_BOOT, mtvec_init);
    pc_ctrl.pc_set <= 1'b0;
    while (got < want) begin
      step_cycle();
    end
    check_flag({cur_name, " outstanding limit"}, 1'b1, max_outst <= FIFO_DEPTH);
    $display("test %s: %0d of %0d words checked, %0d errors",
             cur_name, got, want, test_errors);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    boot_addr   = '0;
    fetch_req   = 1'b1;
    pc_ctrl     = '0;
    csr         = '0;
    jump_target = '0;
    id_ready    = 1'b1;
    valid_clear = 1'b0;
    err_lo      = '1;
    err_hi      = '0;
    want        = 0;
    got         = 0;
    skip        = 0;
    head_pc     = '0;
    cur_name    = "startup";
    rnd         = $urandom(SEED);

    load_tests();
    cycle_limit = 40 * total_words + 200;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    check_reset();
    for (int unsigned i = 0; i < n_tests; i++) begin
      run_test(i);
    end

    $display("%0d tests run, %0d checks, %0d errors", n_tests + 1, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb/instr_mem_model.sv */
// instruction memory model
// grants word fetches after a random gap and returns them in order,
// data is the address scrambled with a fixed key

`timescale 1ns/1ns

module instr_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  if_pkg::instr_bus_req_t bus_req_i,
  input  if_pkg::pc_t            err_lo_i,
  input  if_pkg::pc_t            err_hi_i,
  output if_pkg::instr_bus_rsp_t bus_rsp_o
);
  import if_pkg::*;

  localparam pc_t DATA_KEY = 32'hA5A5_0000;

  // granted addresses and the cycle each one is answered in
  pc_t         addr_q [$];
  int unsigned due_q [$];
  int unsigned cycle_no;
  int unsigned last_due;
  int unsigned due;
  int unsigned gap;
  pc_t         rsp_addr;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q.delete();
      due_q.delete();
      cycle_no  = 0;
      last_due  = 0;
      gap       = 0;
      bus_rsp_o <= '0;
    end else begin
      cycle_no = cycle_no + 1;

      //////////////////////////////////////////////////////////////////
      // grant side
      //////////////////////////////////////////////////////////////////
      if (bus_req_i.req && bus_rsp_o.gnt) begin
        // answer 1 to 4 cycles after the grant, never before an older one
        due = cycle_no + ($urandom % 4);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        addr_q.push_back(bus_req_i.addr);
        due_q.push_back(due);
        // gnt drops for 0 to 3 cycles after each accepted request
        gap = $urandom % 4;
        bus_rsp_o.gnt <= (gap == 0);
      end else if (gap != 0) begin
        gap = gap - 1;
        bus_rsp_o.gnt <= (gap == 0);
      end else begin
        bus_rsp_o.gnt <= 1'b1;
      end

      //////////////////////////////////////////////////////////////////
      // response side
      //////////////////////////////////////////////////////////////////
      if (due_q.size() != 0 && due_q[0] <= cycle_no) begin
        rsp_addr = addr_q.pop_front();
        due      = due_q.pop_front();
        bus_rsp_o.rvalid <= 1'b1;
        bus_rsp_o.rdata  <= rsp_addr ^ DATA_KEY;
        bus_rsp_o.err    <= (rsp_addr >= err_lo_i) && (rsp_addr <= err_hi_i);
      end else begin
        bus_rsp_o.rvalid <= 1'b0;
        bus_rsp_o.rdata  <= '0;
        bus_rsp_o.err    <= 1'b0;
      end
    end
  end

endmodule

/* verilog/if_stage.sv */
// instruction fetch stage top
// next-PC selection, bus prefetch with fetch buffer, and the IF-ID
// pipeline register feeding the decode stage

`timescale 1ns/1ns

module if_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  if_pkg::pc_t            boot_addr_i,
  input  logic                   req_i,

  // PC change command, CSR addresses and jump target
  input  if_pkg::pc_ctrl_t       pc_ctrl_i,
  input  if_pkg::csr_pc_t        csr_i,
  input  if_pkg::pc_t            jump_target_i,

  // instruction bus
  output if_pkg::instr_bus_req_t bus_req_o,
  input  if_pkg::instr_bus_rsp_t bus_rsp_i,

  // decode stage handshake
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  output if_pkg::id_instr_t      instr_id_o,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,

  output if_pkg::pc_t            pc_if_o,
  output logic                   csr_mtvec_init_o,
  output logic                   if_busy_o
);
  import if_pkg::*;

  // next fetch address from the PC mux
  pc_t          fetch_addr_n;

  // fetch buffer head towards the IF-ID register
  fetch_entry_t fetch;
  logic         fetch_valid;
  logic         fetch_ready;

  pc_select i_pc_select (
    .boot_addr_i      (boot_addr_i),
    .pc_ctrl_i        (pc_ctrl_i),
    .csr_i            (csr_i),
    .jump_target_i    (jump_target_i),
    .fetch_addr_o     (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // every pc_set is a branch for the prefetcher
  prefetch_buffer i_prefetch_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (pc_ctrl_i.pc_set),
    .branch_addr_i (fetch_addr_n),
    .bus_req_o     (bus_req_o),
    .bus_rsp_i     (bus_rsp_i),
    .fetch_o       (fetch),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .busy_o        (if_busy_o)
  );

  if_id_reg i_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_i             (fetch),
    .fetch_valid_i       (fetch_valid),
    .fetch_ready_o       (fetch_ready),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_ctrl_i.pc_set),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_id_o          (instr_id_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o)
  );

  // address of the word waiting at the buffer head
  assign pc_if_o = fetch.addr;

endmodule

/* verilog/if_id_reg.sv */
// IF-ID pipeline register
// takes the fetch buffer head when decode is ready and keeps the
// valid and new flags seen by the decode stage

`timescale 1ns/1ns

module if_id_reg (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  if_pkg::fetch_entry_t fetch_i,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  logic                 id_in_ready_i,
  input  logic                 pc_set_i,
  input  logic                 instr_valid_clear_i,
  output if_pkg::id_instr_t    instr_id_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o
);
  import if_pkg::*;

  logic      pop;
  logic      valid_d;
  logic      valid_q;
  logic      new_q;
  id_instr_t instr_q;

  // decode accepts whenever it is ready, the buffer pops on the handshake
  assign fetch_ready_o = id_in_ready_i;
  assign pop           = fetch_valid_i & fetch_ready_o;

  // a word taken in the pc_set cycle belongs to the old stream
  // valid then holds until decode clears it
  assign valid_d = (pop & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one-cycle pulse for every word entering decode
      new_q   <= pop;
    end
  end

  // frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (pop) begin
      instr_q.instr     <= fetch_i.rdata;
      instr_q.pc        <= fetch_i.addr;
      instr_q.fetch_err <= fetch_i.err;
    end
  end

  assign instr_id_o       = instr_q;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

/* verilog/pc_select.sv */
// next-PC selection
// builds the exception vector and picks the next fetch address,
// flags mtvec initialisation on boot

`timescale 1ns/1ns

module pc_select (
  input  if_pkg::pc_t      boot_addr_i,
  input  if_pkg::pc_ctrl_t pc_ctrl_i,
  input  if_pkg::csr_pc_t  csr_i,
  input  if_pkg::pc_t      jump_target_i,
  output if_pkg::pc_t      fetch_addr_o,
  output logic             csr_mtvec_init_o
);
  import if_pkg::*;

  pc_t boot_base;
  pc_t mtvec_base;
  pc_t exc_pc;

  // low bits of both bases are not used
  assign boot_base  = {boot_addr_i[ADDR_W-1:BOOT_ALIGN_W], {BOOT_ALIGN_W{1'b0}}};
  assign mtvec_base = {csr_i.mtvec[ADDR_W-1:BOOT_ALIGN_W], {BOOT_ALIGN_W{1'b0}}};

  // vectored interrupts land at base + 4 * irq_id
  always_comb begin
    unique case (pc_ctrl_i.exc_pc_mux)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      EXC_PC_IRQ:     exc_pc = mtvec_base + {{(ADDR_W-7){1'b0}}, pc_ctrl_i.irq_id, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  always_comb begin
    unique case (pc_ctrl_i.pc_mux)
      PC_BOOT: fetch_addr_o = boot_base;
      PC_JUMP: fetch_addr_o = jump_target_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap handler
      PC_ERET: fetch_addr_o = csr_i.mepc;
      // return from debug mode
      PC_DRET: fetch_addr_o = csr_i.depc;
      default: fetch_addr_o = boot_base;
    endcase
  end

  // CSR file loads mtvec from the boot address on the boot jump
  assign csr_mtvec_init_o = pc_ctrl_i.pc_set & (pc_ctrl_i.pc_mux == PC_BOOT);

  // legal PC source on a PC change and a 256-byte aligned boot address
  always_comb begin
    if (pc_ctrl_i.pc_set) begin
      assert final (!$isunknown(pc_ctrl_i.pc_mux) &&
                    (pc_ctrl_i.pc_mux inside {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET, PC_DRET}))
        else $error("pc_mux unknown or illegal while pc_set is high");
    end
    if (!$isunknown(boot_addr_i)) begin
      assert final (boot_addr_i[BOOT_ALIGN_W-1:0] == '0)
        else $error("boot address not aligned to 256 bytes");
    end
  end

endmodule

/* prefetch/prefetch_buffer.sv */
// prefetch controller
// issues word fetches on the instruction bus, counts outstanding and
// stale responses, and pushes the live ones into the fetch buffer

`timescale 1ns/1ns

module prefetch_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  if_pkg::pc_t            branch_addr_i,
  output if_pkg::instr_bus_req_t bus_req_o,
  input  if_pkg::instr_bus_rsp_t bus_rsp_i,
  output if_pkg::fetch_entry_t   fetch_o,
  output logic                   fetch_valid_o,
  input  logic                   fetch_ready_i,
  output logic                   busy_o
);
  import if_pkg::*;

  pc_t              branch_addr_al;
  // address of the next request
  pc_t              req_addr_q;
  // address of the next live response
  pc_t              rsp_addr_q;
  // no fetching before the first branch after reset
  logic             fetch_en_q;
  logic [CNT_W-1:0] outst_q;
  logic [CNT_W-1:0] outst_d;
  logic [CNT_W-1:0] stale_q;
  logic [CNT_W-1:0] stale_d;
  logic [CNT_W-1:0] fifo_cnt;
  logic [CNT_W:0]   occupancy;
  logic             bus_req;
  logic             req_acc;
  logic             rsp_stale;
  logic             push;
  fetch_entry_t     push_entry;

  assign branch_addr_al = {branch_addr_i[ADDR_W-1:2], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // in-flight plus buffered words never exceed the buffer depth
  assign occupancy = {1'b0, outst_q} + {1'b0, fifo_cnt};

  // held low in the branch cycle, the new stream starts one cycle later
  assign bus_req   = req_i & fetch_en_q & ~branch_i & (occupancy < FIFO_DEPTH);
  assign req_acc   = bus_req & bus_rsp_i.gnt;
  assign bus_req_o = '{req: bus_req, addr: req_addr_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q <= 1'b0;
      req_addr_q <= '0;
      rsp_addr_q <= '0;
    end else if (branch_i) begin
      fetch_en_q <= 1'b1;
      req_addr_q <= branch_addr_al;
      rsp_addr_q <= branch_addr_al;
    end else begin
      // sequential fetch, step by one word
      if (req_acc) begin
        req_addr_q <= req_addr_q + 32'd4;
      end
      if (push) begin
        rsp_addr_q <= rsp_addr_q + 32'd4;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  // responses come back in order, so stale ones are always the oldest
  assign rsp_stale = (stale_q != '0);

  always_comb begin
    outst_d = outst_q;
    if (req_acc && !bus_rsp_i.rvalid) begin
      outst_d = outst_q + 1'b1;
    end else if (!req_acc && bus_rsp_i.rvalid) begin
      outst_d = outst_q - 1'b1;
    end

    stale_d = stale_q;
    if (branch_i) begin
      // all remaining in-flight words belong to the old stream
      stale_d = bus_rsp_i.rvalid ? outst_q - 1'b1 : outst_q;
    end else if (bus_rsp_i.rvalid && rsp_stale) begin
      stale_d = stale_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
      stale_q <= '0;
    end else begin
      outst_q <= outst_d;
      stale_q <= stale_d;
    end
  end

  // drop stale words and anything arriving with the branch
  assign push       = bus_rsp_i.rvalid & ~rsp_stale & ~branch_i;
  assign push_entry = '{addr: rsp_addr_q, rdata: bus_rsp_i.rdata, err: bus_rsp_i.err};

  fetch_fifo i_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (branch_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .pop_i        (fetch_ready_i),
    .head_o       (fetch_o),
    .valid_o      (fetch_valid_o),
    .count_o      (fifo_cnt)
  );

  assign busy_o = bus_req | (outst_q != '0);

  // requested addresses are clean word addresses
  req_addr_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req |-> !$isunknown(req_addr_q) && (req_addr_q[1:0] == 2'b00));

  outst_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outst_q <= FIFO_DEPTH);

  // the bus answers only what was granted earlier
  rvalid_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_i.rvalid |-> (outst_q != '0));

endmodule

/* prefetch/fetch_fifo.sv */
// fetch buffer
// in-order buffer of fetched words with address and error flag,
// cleared in one cycle on a branch

`timescale 1ns/1ns

module fetch_fifo (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     push_i,
  input  if_pkg::fetch_entry_t     push_entry_i,
  input  logic                     pop_i,
  output if_pkg::fetch_entry_t     head_o,
  output logic                     valid_o,
  output logic [if_pkg::CNT_W-1:0] count_o
);
  import if_pkg::*;

  fetch_entry_t          mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  do_pop;

  // circular pointer step
  function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
    logic [FIFO_PTR_W-1:0] nxt;
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // pop only what is there
  assign do_pop = pop_i & valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push_i && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage, a pushed word shows at the head from the next cycle
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign count_o = count_q;

  // the controller's request limit keeps room for every response
  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q < FIFO_DEPTH));

endmodule

/* common/if_pkg.sv */
// instruction fetch stage package
// widths, fixed debug entry addresses, selector enums and the structs
// passed between PC mux, prefetch buffer and IF-ID register

package if_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and depths
  //////////////////////////////////////////////////////////////////////

  // address and instruction word width
  localparam int unsigned ADDR_W       = 32;
  // boot and mtvec bases are aligned to 256 bytes
  localparam int unsigned BOOT_ALIGN_W = 8;

  // fetch buffer depth, also the cap on outstanding bus fetches
  localparam int unsigned FIFO_DEPTH   = 2;
  localparam int unsigned FIFO_PTR_W   = $clog2(FIFO_DEPTH);
  // counters must hold 0 .. FIFO_DEPTH inclusive
  localparam int unsigned CNT_W        = $clog2(FIFO_DEPTH + 1);

  typedef logic [ADDR_W-1:0] pc_t;

  // debug module entry points
  localparam pc_t DM_HALT_ADDR = 32'h1A11_0800;
  localparam pc_t DM_EXC_ADDR  = 32'h1A11_0808;

  //////////////////////////////////////////////////////////////////////
  // selectors
  //////////////////////////////////////////////////////////////////////

  // next-PC source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of exception vector used with PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////

  // PC change command from the controller
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    logic [4:0]  irq_id;
  } pc_ctrl_t;

  // addresses supplied by the CSR file
  typedef struct packed {
    pc_t mepc;
    pc_t depc;
    pc_t mtvec;
  } csr_pc_t;

  typedef struct packed {
    logic req;
    pc_t  addr;
  } instr_bus_req_t;

  typedef struct packed {
    logic gnt;
    logic rvalid;
    pc_t  rdata;
    logic err;
  } instr_bus_rsp_t;

  // one fetched word as held in the fetch buffer
  typedef struct packed {
    pc_t  addr;
    pc_t  rdata;
    logic err;
  } fetch_entry_t;

  // IF-ID pipeline register contents
  typedef struct packed {
    pc_t  instr;
    pc_t  pc;
    logic fetch_err;
  } id_instr_t;

endpackage
